// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_blur_core, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f sources.f \
		--top-module tb_blur_core -Mdir obj_dir -o sim_blur
	./obj_dir/sim_blur | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/tb_blur_core.sv
module tb_blur_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RUN_CYCLES = 2 * blur_pkg::IMG_H + 16; // one run with margin
    localparam int MAX_CYCLES = 8 * RUN_CYCLES + 200;     // whole session budget

    logic                clk;
    logic                rst_n;
    logic                start;
    logic                img_we;
    blur_pkg::row_addr_t img_addr;
    blur_pkg::row_t      img_din;
    blur_pkg::row_addr_t blur_rd_addr;
    logic                done;
    blur_pkg::row_t      blur_dout;

    blur_pkg::row_t image    [blur_pkg::IMG_H]; // stimulus rows
    blur_pkg::row_t expected [blur_pkg::IMG_H]; // reference result
    logic [31:0]    lcg_state;                  // random generator state
    int             cycles = 0;                 // clock count since time 0

    blur_core dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .img_we       (img_we),
        .img_addr     (img_addr),
        .img_din      (img_din),
        .blur_rd_addr (blur_rd_addr),
        .done         (done),
        .blur_dout    (blur_dout)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk; // 100 ns period

    always @(posedge clk) begin
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "simulation stopped by timeout");
        end else begin
            cycles <= cycles + 1;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223; // numerical recipes constants
        return lcg_state;
    endfunction

    function automatic int pixel_at(int y, int x);
        if (y < 0 || y >= blur_pkg::IMG_H || x < 0 || x >= blur_pkg::IMG_W) begin
            return 0; // outside the image reads as zero
        end
        return int'(image[y][x*blur_pkg::PIX_W +: blur_pkg::PIX_W]);
    endfunction

    // direct 3x3 sum, weights are the outer product of 1 2 1
    function automatic blur_pkg::pixel_t blur_pixel(int y, int x);
        int sum;
        int w;
        sum = 0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                w = (dy == 0 ? 2 : 1) * (dx == 0 ? 2 : 1);
                sum += w * pixel_at(y + dy, x + dx);
            end
        end
        return blur_pkg::pixel_t'((sum + 8) / 16); // round half up
    endfunction

    task automatic set_expected(int y, int x, int v);
        expected[y][x*blur_pkg::PIX_W +: blur_pkg::PIX_W] = blur_pkg::pixel_t'(v);
    endtask

    task automatic compute_expected();
        for (int y = 0; y < blur_pkg::IMG_H; y++) begin
            for (int x = 0; x < blur_pkg::IMG_W; x++) begin
                set_expected(y, x, int'(blur_pixel(y, x)));
            end
        end
    endtask

    task automatic fill_random();
        logic [31:0] rnd;
        for (int y = 0; y < blur_pkg::IMG_H; y++) begin
            for (int x = 0; x < blur_pkg::IMG_W; x++) begin
                rnd = lcg_next();
                image[y][x*blur_pkg::PIX_W +: blur_pkg::PIX_W] = rnd[23:16]; // upper bits
            end
        end
    endtask

    task automatic check_row(string name, blur_pkg::row_t exp, blur_pkg::row_t got);
        if (got !== exp) begin
            $display("[FAIL] %s exp=%h got=%h", name, exp, got);
            $display("Test failed");
            $fatal(1, "row mismatch");
        end
    endtask

    task automatic check_bit(string name, logic exp, logic got);
        if (got !== exp) begin
            $display("[FAIL] %s exp=%h got=%h", name, exp, got);
            $display("Test failed");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic load_image();
        for (int r = 0; r < blur_pkg::IMG_H; r++) begin
            @(negedge clk);
            img_we   = 1'b1;
            img_addr = blur_pkg::row_addr_t'(r);
            img_din  = image[r];
        end
        @(negedge clk);
        img_we = 1'b0; // last row lands on the edge before
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0; // sampled on exactly one edge
    endtask

    task automatic wait_done();
        while (done !== 1'b1) begin
            @(negedge clk); // bounded by the cycle counter
        end
    endtask

    task automatic run_blur();
        pulse_start();
        wait_done();
    endtask

    task automatic read_back();
        for (int r = 0; r < blur_pkg::IMG_H; r++) begin
            @(negedge clk);
            blur_rd_addr = blur_pkg::row_addr_t'(r);
            @(negedge clk); // registered read
            check_row($sformatf("blur_dout[%0d]", r), expected[r], blur_dout);
        end
    endtask

    task automatic test_reset_done();
        check_bit("done", 1'b0, done); // idle after reset
        for (int r = 0; r < blur_pkg::IMG_H; r++) begin
            image[r] = '0;
        end
        load_image();
        run_blur();
        check_bit("done", 1'b1, done);
        pulse_start();
        check_bit("done", 1'b0, done); // dropped on the accepting edge
        wait_done();
    endtask

    task automatic test_uniform();
        int v;
        for (int y = 0; y < blur_pkg::IMG_H; y++) begin
            image[y] = {blur_pkg::IMG_W{8'd100}};
            for (int x = 0; x < blur_pkg::IMG_W; x++) begin
                v = 100; // interior
                if ((y == 0 || y == blur_pkg::IMG_H - 1) && (x == 0 || x == blur_pkg::IMG_W - 1))
                    v = 56; // corner, 900 of 1600
                else if (y == 0 || y == blur_pkg::IMG_H - 1 || x == 0 || x == blur_pkg::IMG_W - 1)
                    v = 75; // edge, 1200 of 1600
                set_expected(y, x, v);
            end
        end
        load_image();
        run_blur();
        read_back();
    endtask

    task automatic test_impulse();
        int w;
        for (int r = 0; r < blur_pkg::IMG_H; r++) begin
            image[r]    = '0;
            expected[r] = '0;
        end
        image[5][7*blur_pkg::PIX_W +: blur_pkg::PIX_W] = 8'd255;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                w = (dy == 0 ? 2 : 1) * (dx == 0 ? 2 : 1); // 4 centre, 2 side, 1 diagonal
                set_expected(5 + dy, 7 + dx, (255 * w + 8) / 16);
            end
        end
        load_image();
        run_blur();
        read_back();
    endtask

    task automatic test_random();
        fill_random();
        compute_expected();
        load_image();
        run_blur();
        read_back();
    endtask

    task automatic test_rerun();
        fill_random(); // second image, generator carries on
        compute_expected();
        load_image();
        pulse_start();
        repeat (4) @(negedge clk);
        check_bit("done", 1'b0, done); // still busy
        pulse_start();                 // must be ignored
        wait_done();
        // a second accepted start would pull done low again
        repeat (RUN_CYCLES) begin
            @(negedge clk);
            check_bit("done", 1'b1, done);
        end
        read_back();
    endtask

    initial begin
        lcg_state    = 32'h16b2_c78c;
        rst_n        = 1'b0;
        start        = 1'b0;
        img_we       = 1'b0;
        img_addr     = '0;
        img_din      = '0;
        blur_rd_addr = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        test_reset_done();
        test_uniform();
        test_impulse();
        test_random();
        test_rerun();
        $display("Test passed");
        $finish;
    end

endmodule

// File: sources.f
src/blur_pkg.sv
src/row_ram.sv
src/line_buffer.sv
src/gaussian_kernel_row.sv
src/gaussian_blur.sv
src/blur_core.sv
bench/tb_blur_core.sv

// File: src/blur_core.sv
module blur_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,        // run strobe
    input  logic                img_we,       // host image row write
    input  blur_pkg::row_addr_t img_addr,     // host write row
    input  blur_pkg::row_t      img_din,      // host write data
    input  blur_pkg::row_addr_t blur_rd_addr, // host readback row
    output logic                done,         // level, blurred image ready
    output blur_pkg::row_t      blur_dout     // readback data, next edge
);

    blur_pkg::blur_state_t state;      // sequencer
    blur_pkg::blur_state_t state_nxt;

    logic                blur_go;      // run pulse to the engine
    logic                blur_finish;  // engine finished last row
    blur_pkg::row_addr_t img_rd_addr;  // engine read row
    blur_pkg::row_t      img_rd_data;
    logic                blur_we;      // engine writes
    blur_pkg::row_addr_t blur_wr_addr;
    blur_pkg::row_t      blur_wr_data;

    // start only counts outside a run
    assign blur_go = start && (state != blur_pkg::ST_BLUR);

    always_comb begin
        state_nxt = state;
        case (state)
            blur_pkg::ST_IDLE: if (blur_go) state_nxt = blur_pkg::ST_BLUR;
            blur_pkg::ST_BLUR: if (blur_finish) state_nxt = blur_pkg::ST_DONE;
            blur_pkg::ST_DONE: if (blur_go) state_nxt = blur_pkg::ST_BLUR; // rerun
            default:           state_nxt = blur_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= blur_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign done = (state == blur_pkg::ST_DONE); // drops on edge after accepted start

    // host writes, engine reads
    row_ram #(.DEPTH(blur_pkg::IMG_H), .WIDTH(blur_pkg::ROW_W)) img_ram (
        .clk     (clk),
        .we      (img_we),
        .wr_addr (img_addr),
        .rd_addr (img_rd_addr),
        .din     (img_din),
        .dout    (img_rd_data)
    );

    // engine writes, host reads
    row_ram #(.DEPTH(blur_pkg::IMG_H), .WIDTH(blur_pkg::ROW_W)) blur_ram (
        .clk     (clk),
        .we      (blur_we),
        .wr_addr (blur_wr_addr),
        .rd_addr (blur_rd_addr),
        .din     (blur_wr_data),
        .dout    (blur_dout)
    );

    gaussian_blur u_gaussian_blur (
        .clk          (clk),
        .rst_n        (rst_n),
        .go           (blur_go),
        .img_rd_addr  (img_rd_addr),
        .img_rd_data  (img_rd_data),
        .blur_we      (blur_we),
        .blur_wr_addr (blur_wr_addr),
        .blur_wr_data (blur_wr_data),
        .finish       (blur_finish)
    );

    // image memory is being read during a run
    a_no_load_in_blur: assert property (
        @(posedge clk) disable iff (!rst_n) (state == blur_pkg::ST_BLUR) |-> !img_we
    );

    // engine completion only inside a run
    a_finish_in_blur: assert property (
        @(posedge clk) disable iff (!rst_n) blur_finish |-> (state == blur_pkg::ST_BLUR)
    );

endmodule

// File: src/blur_pkg.sv
package blur_pkg;

    // image geometry, scaled-down sizes
    localparam int IMG_W  = 16;            // pixels per row
    localparam int IMG_H  = 16;            // rows per image
    localparam int PIX_W  = 8;             // grayscale depth
    localparam int ROW_W  = IMG_W * PIX_W; // one memory word holds a full row
    localparam int ADDR_W = 4;             // row index width

    // kernel 1 2 1 / 2 4 2 / 1 2 1, weight total 16
    localparam int KERNEL_SHIFT = 4;                  // divide by 16
    localparam int ACC_W        = PIX_W + KERNEL_SHIFT; // 255*16 = 4080 fits

    typedef logic [PIX_W-1:0]  pixel_t;    // one pixel
    typedef logic [ROW_W-1:0]  row_t;      // pixel x at bits x*8 upward
    typedef logic [ADDR_W-1:0] row_addr_t; // row index
    typedef logic [ACC_W-1:0]  acc_t;      // weighted kernel sum

    // top-level sequencer
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0, // waiting for first start
        ST_BLUR = 2'd1, // engine running
        ST_DONE = 2'd2  // result valid, new start allowed
    } blur_state_t;

endpackage

// File: src/gaussian_blur.sv
module gaussian_blur (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                go,           // one-cycle run request
    output blur_pkg::row_addr_t img_rd_addr,  // image memory read row
    input  blur_pkg::row_t      img_rd_data,  // arrives one cycle after addr
    output logic                blur_we,      // blur memory write strobe
    output blur_pkg::row_addr_t blur_wr_addr, // blurred row index
    output blur_pkg::row_t      blur_wr_data, // kernel output
    output logic                finish        // pulse after last row write
);

    localparam blur_pkg::row_addr_t LAST_ROW = blur_pkg::row_addr_t'(blur_pkg::IMG_H - 1);

    logic                clr_q;      // line buffer clear, cycle after go
    logic                rd_active;  // image rows still being read
    blur_pkg::row_addr_t rd_cnt;     // next row to read
    logic                fill_slot;  // zero-fill slot after last read
    logic                shift_q;    // read data valid, shift it in
    logic                fill_q;     // shift carries zeros
    logic                primed;     // at least one shift since clear
    logic                we_q;       // write strobe
    blur_pkg::row_addr_t wr_addr;    // row being written
    logic                finish_q;   // end-of-run pulse
    logic                wr_wrapped; // last row already written this run

    logic           rd_last;  // final image row on the read port
    logic           wr_last;  // final blurred row being written
    blur_pkg::row_t row_top;
    blur_pkg::row_t row_mid;
    blur_pkg::row_t row_bot;

    assign rd_last = rd_active && (rd_cnt == LAST_ROW);
    assign wr_last = we_q && (wr_addr == LAST_ROW);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clr_q      <= 1'b0;
            rd_active  <= 1'b0;
            rd_cnt     <= '0;
            fill_slot  <= 1'b0;
            shift_q    <= 1'b0;
            fill_q     <= 1'b0;
            primed     <= 1'b0;
            we_q       <= 1'b0;
            wr_addr    <= '0;
            finish_q   <= 1'b0;
            wr_wrapped <= 1'b0;
        end else begin
            clr_q     <= go;                     // clear then read row 0
            fill_slot <= rd_last;                // one slot past the last row
            shift_q   <= rd_active || fill_slot; // ram latency of one
            fill_q    <= fill_slot;
            we_q      <= shift_q && primed;      // shift k>=2 yields row k-2
            finish_q  <= wr_last;

            if (go) begin
                rd_active <= 1'b1;
                rd_cnt    <= '0;
            end else if (rd_active) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_last) begin
                    rd_active <= 1'b0;
                end
            end

            if (clr_q) begin
                primed     <= 1'b0;
                wr_addr    <= '0;
                wr_wrapped <= 1'b0;
            end else begin
                if (shift_q) begin
                    primed <= 1'b1;
                end
                if (we_q) begin
                    wr_addr <= wr_addr + 1'b1; // wraps to 0 after last row
                end
                if (wr_last) begin
                    wr_wrapped <= 1'b1;
                end
            end
        end
    end

    assign img_rd_addr = rd_cnt;

    line_buffer u_line_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift     (shift_q),
        .clear     (clr_q),
        .fill_zero (fill_q),
        .in_row    (img_rd_data),
        .row_top   (row_top),
        .row_mid   (row_mid),
        .row_bot   (row_bot)
    );

    // window now centred on row wr_addr
    gaussian_kernel_row u_kernel (
        .row_top  (row_top),
        .row_mid  (row_mid),
        .row_bot  (row_bot),
        .blur_row (blur_wr_data)
    );

    assign blur_we      = we_q;
    assign blur_wr_addr = wr_addr;
    assign finish       = finish_q;

    // once the address counter has wrapped, no further row may be written
    a_no_write_past_last: assert property (
        @(posedge clk) disable iff (!rst_n) blur_we |-> !wr_wrapped
    );

endmodule

// File: src/gaussian_kernel_row.sv
module gaussian_kernel_row (
    input  blur_pkg::row_t row_top,  // row y-1
    input  blur_pkg::row_t row_mid,  // row y
    input  blur_pkg::row_t row_bot,  // row y+1
    output blur_pkg::row_t blur_row  // blurred row y
);

    // Separable form: vertical 1 2 1 per column, then horizontal 1 2 1.
    // Slots 0 and IMG_W+1 stay zero and give the column padding.
    always_comb begin
        blur_pkg::acc_t col [blur_pkg::IMG_W+2]; // vertical sums, max 1020
        blur_pkg::acc_t sum;                     // full 3x3 sum, max 4080
        blur_pkg::acc_t rnd;                     // sum plus half lsb

        col[0] = '0;                 // left padding
        col[blur_pkg::IMG_W+1] = '0; // right padding
        for (int c = 0; c < blur_pkg::IMG_W; c++) begin
            col[c+1] = blur_pkg::acc_t'(row_top[c*blur_pkg::PIX_W +: blur_pkg::PIX_W])
                     + (blur_pkg::acc_t'(row_mid[c*blur_pkg::PIX_W +: blur_pkg::PIX_W]) << 1)
                     + blur_pkg::acc_t'(row_bot[c*blur_pkg::PIX_W +: blur_pkg::PIX_W]);
        end

        blur_row = '0;
        for (int x = 0; x < blur_pkg::IMG_W; x++) begin
            sum = col[x] + (col[x+1] << 1) + col[x+2];                 // x-1, x, x+1
            rnd = sum + (blur_pkg::acc_t'(1) << (blur_pkg::KERNEL_SHIFT - 1)); // +8
            blur_row[x*blur_pkg::PIX_W +: blur_pkg::PIX_W] =
                blur_pkg::pixel_t'(rnd >> blur_pkg::KERNEL_SHIFT); // /16
        end
    end

endmodule

// File: src/line_buffer.sv
module line_buffer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           shift,     // advance one row
    input  logic           clear,     // zero all rows, top padding
    input  logic           fill_zero, // shift in zeros, bottom padding
    input  blur_pkg::row_t in_row,    // row from image memory
    output blur_pkg::row_t row_top,   // oldest row
    output blur_pkg::row_t row_mid,   // centre row of the window
    output blur_pkg::row_t row_bot    // newest row
);

    blur_pkg::row_t top_q; // row y-1
    blur_pkg::row_t mid_q; // row y
    blur_pkg::row_t bot_q; // row y+1

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_q <= '0;
            mid_q <= '0;
            bot_q <= '0;
        end else if (clear) begin
            top_q <= '0; // padding above row 0
            mid_q <= '0;
            bot_q <= '0;
        end else if (shift) begin
            top_q <= mid_q; // oldest row drops out
            mid_q <= bot_q;
            if (fill_zero) begin
                bot_q <= '0; // padding below last row
            end else begin
                bot_q <= in_row;
            end
        end
    end

    assign row_top = top_q;
    assign row_mid = mid_q;
    assign row_bot = bot_q;

    // controller keeps clear and shift in separate cycles
    a_clear_shift_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(clear && shift)
    );

endmodule

// File: src/row_ram.sv
module row_ram #(
    parameter int DEPTH = blur_pkg::IMG_H, // words
    parameter int WIDTH = blur_pkg::ROW_W  // bits per word
) (
    input  logic                clk,
    input  logic                we,      // write strobe
    input  blur_pkg::row_addr_t wr_addr, // write row
    input  blur_pkg::row_addr_t rd_addr, // read row
    input  logic [WIDTH-1:0]    din,     // write data
    output logic [WIDTH-1:0]    dout     // read data, one clock late
);

    logic [WIDTH-1:0] mem [DEPTH]; // row storage

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= din; // write lands on this edge
        end
    end

    // registered read, old data on same-address collision
    always_ff @(posedge clk) begin
        dout <= mem[rd_addr];
    end

endmodule
